//--- hdl/lstm_weight_pkg.sv
package lstm_weight_pkg;

	// Lane format, 18-bit fixed point
	localparam int WEIGHT_W = 18;

	// Lanes presented per bank line
	localparam int LANES = 9;

	// Input sub-blocks per weight row
	localparam int COLS = 42;

	// Weight rows
	localparam int ROWS = 64;

	localparam int DEPTH = COLS * ROWS;
	localparam int INDEX_W = $clog2(DEPTH);
	localparam int LANE_W = $clog2(LANES);

	// Input, forget, output and cell activation gates, in that order
	localparam int GATES = 4;

	// Bank number is gate * 2 + part, part 0 real and part 1 imaginary
	localparam int BANKS = GATES * 2;

endpackage

//--- hdl/axi_map_pkg.sv
package axi_map_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register numbers in the control region
	localparam logic [3:0] REG_CTRL = 4'd0;
	localparam logic [3:0] REG_STATUS = 4'd1;

	// CTRL bit positions
	localparam int CTRL_RUN = 0;
	localparam int CTRL_REWIND = 1;

	// Weight region, bit 21 clear
	typedef struct packed {
		logic [9:0] reserved;
		logic region;
		logic [1:0] gate;
		logic part;
		logic [11:0] index;
		logic [3:0] lane;
		logic [1:0] byte_off;
	} weight_addr_t;

	// Control region, bit 21 set
	typedef struct packed {
		logic [9:0] reserved_hi;
		logic region;
		logic [14:0] reserved_lo;
		logic [3:0] reg_num;
		logic [1:0] byte_off;
	} ctrl_addr_t;

	typedef union packed {
		weight_addr_t weight;
		ctrl_addr_t ctrl;
	} axi_addr_u;

endpackage

//--- hdl/weight_index_counter.sv
`timescale 1ns/1ps

module weight_index_counter (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic rewind,
	input  logic incr_index,
	output logic [5:0] col,
	output logic [5:0] row,
	output logic [lstm_weight_pkg::INDEX_W-1:0] rd_index
);
	import lstm_weight_pkg::*;

	logic step;
	logic col_wrap;
	logic row_wrap;

	assign step = run && incr_index;
	assign col_wrap = (col == COLS - 1);
	assign row_wrap = (row == ROWS - 1);

	always_ff @(posedge clk) begin
		if (reset || rewind) begin
			col <= '0;
			row <= '0;
			rd_index <= '0;
		end else if (step) begin
			if (col_wrap) begin
				col <= '0;
				if (row_wrap) begin
					row <= '0;
				end else begin
					row <= row + 6'd1;
				end
			end else begin
				col <= col + 6'd1;
			end
			// Running sum instead of row * COLS + col
			if (col_wrap && row_wrap) begin
				rd_index <= '0;
			end else begin
				rd_index <= rd_index + 1'b1;
			end
		end
	end

	col_range_a: assert property (
		@(posedge clk) disable iff (reset)
		col < COLS
	);

	row_range_a: assert property (
		@(posedge clk) disable iff (reset)
		row < ROWS
	);

	// Running sum stays in step with the two counters
	index_sum_a: assert property (
		@(posedge clk) disable iff (reset)
		int'(rd_index) == int'(row) * COLS + int'(col)
	);

endmodule

//--- hdl/weight_load_slave.sv
`timescale 1ns/1ps

module weight_load_slave (
	input  logic clk,
	input  logic reset,
	input  logic [axi_map_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [axi_map_pkg::AXI_DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [axi_map_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [axi_map_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic [5:0] col,
	input  logic [5:0] row,
	output logic run,
	output logic rewind,
	output logic [lstm_weight_pkg::BANKS-1:0] bank_we,
	output logic [lstm_weight_pkg::INDEX_W-1:0] wr_index,
	output logic [lstm_weight_pkg::LANE_W-1:0] wr_lane,
	output logic [lstm_weight_pkg::WEIGHT_W-1:0] wr_data
);
	import lstm_weight_pkg::*;
	import axi_map_pkg::*;

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] WRITE_RESP = 2'd1;
	localparam logic [1:0] READ_RESP = 2'd2;

	logic [1:0] state;
	axi_addr_u aw_addr;
	axi_addr_u ar_addr;
	logic wr_hs;
	logic rd_hs;
	logic wr_weight_ok;
	logic wr_ctrl_ok;
	logic rd_status;
	logic rd_ctrl;
	logic [AXI_DATA_W-1:0] rd_word;

	assign aw_addr = awaddr;
	assign ar_addr = araddr;

	// Writes win over a read arriving together
	assign wr_hs = (state == IDLE) && awvalid && wvalid;
	assign rd_hs = (state == IDLE) && arvalid && !(awvalid && wvalid);

	assign awready = wr_hs;
	assign wready = wr_hs;
	assign arready = rd_hs;
	assign bvalid = (state == WRITE_RESP);
	assign rvalid = (state == READ_RESP);

	assign wr_weight_ok = !aw_addr.weight.region
		&& (aw_addr.weight.lane < LANES)
		&& (aw_addr.weight.index < DEPTH);
	assign wr_ctrl_ok = aw_addr.ctrl.region && (aw_addr.ctrl.reg_num == REG_CTRL);

	assign wr_index = aw_addr.weight.index;
	assign wr_lane = aw_addr.weight.lane;
	assign wr_data = wdata[WEIGHT_W-1:0];
	assign rewind = wr_hs && wr_ctrl_ok && wdata[CTRL_REWIND];

	// Gate and part select the bank
	always_comb begin
		bank_we = '0;
		if (wr_hs && wr_weight_ok) begin
			bank_we[{aw_addr.weight.gate, aw_addr.weight.part}] = 1'b1;
		end
	end

	assign rd_status = ar_addr.ctrl.region && (ar_addr.ctrl.reg_num == REG_STATUS);
	assign rd_ctrl = ar_addr.ctrl.region && (ar_addr.ctrl.reg_num == REG_CTRL);

	always_comb begin
		rd_word = '0;
		if (rd_status) begin
			rd_word[5:0] = col;
			rd_word[13:8] = row;
		end else if (rd_ctrl) begin
			rd_word[CTRL_RUN] = run;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			run <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (wr_hs) begin
						state <= WRITE_RESP;
						if (wr_ctrl_ok) begin
							run <= wdata[CTRL_RUN];
						end
					end else if (rd_hs) begin
						state <= READ_RESP;
					end
				end
				WRITE_RESP: begin
					if (bready) begin
						state <= IDLE;
					end
				end
				READ_RESP: begin
					if (rready) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Response payload, captured at the address handshake
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp <= (wr_weight_ok || wr_ctrl_ok) ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_hs) begin
			rresp <= (rd_status || rd_ctrl) ? RESP_OKAY : RESP_SLVERR;
			rdata <= rd_word;
		end
	end

	bvalid_hold_a: assert property (
		@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp)
	);

	rvalid_hold_a: assert property (
		@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata)
	);

	bank_we_onehot_a: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(bank_we)
	);

endmodule

//--- hdl/weight_bank.sv
`timescale 1ns/1ps

module weight_bank (
	input  logic clk,
	input  logic we,
	input  logic [lstm_weight_pkg::INDEX_W-1:0] wr_index,
	input  logic [lstm_weight_pkg::LANE_W-1:0] wr_lane,
	input  logic [lstm_weight_pkg::WEIGHT_W-1:0] wr_data,
	input  logic [lstm_weight_pkg::INDEX_W-1:0] rd_index,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] lanes
);
	import lstm_weight_pkg::*;

	// One entry holds a full line of nine lanes
	logic [LANES-1:0][WEIGHT_W-1:0] mem [DEPTH];
	logic [INDEX_W-1:0] rd_addr;

	always_ff @(posedge clk) begin
		rd_addr <= rd_index;
	end

	// Single lane write, whole line read
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_index][wr_lane] <= wr_data;
		end
		lanes <= mem[rd_addr];
	end

	// Lane range is checked by the AXI slave before the strobe
	wr_lane_range_a: assert property (
		@(posedge clk)
		we |-> wr_lane < LANES
	);

endmodule

//--- hdl/stage1_parameter_buffer.sv
`timescale 1ns/1ps

module stage1_parameter_buffer (
	input  logic clk,
	input  logic reset,
	input  logic incr_index,
	input  logic [axi_map_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [axi_map_pkg::AXI_DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [axi_map_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [axi_map_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wixr_real,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wixr_imag,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wfxr_real,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wfxr_imag,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] woxr_real,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] woxr_imag,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wcxr_real,
	output logic [lstm_weight_pkg::LANES-1:0][lstm_weight_pkg::WEIGHT_W-1:0] wcxr_imag
);
	import lstm_weight_pkg::*;

	logic run;
	logic rewind;
	logic [5:0] col;
	logic [5:0] row;
	logic [INDEX_W-1:0] rd_index;
	logic [BANKS-1:0] bank_we;
	logic [INDEX_W-1:0] wr_index;
	logic [LANE_W-1:0] wr_lane;
	logic [WEIGHT_W-1:0] wr_data;
	logic [LANES-1:0][WEIGHT_W-1:0] bank_lanes [BANKS];

	weight_load_slave slave_i (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.col(col),
		.row(row),
		.run(run),
		.rewind(rewind),
		.bank_we(bank_we),
		.wr_index(wr_index),
		.wr_lane(wr_lane),
		.wr_data(wr_data)
	);

	weight_index_counter counter_i (
		.clk(clk),
		.reset(reset),
		.run(run),
		.rewind(rewind),
		.incr_index(incr_index),
		.col(col),
		.row(row),
		.rd_index(rd_index)
	);

	for (genvar b = 0; b < BANKS; b++) begin : g_bank
		weight_bank bank_i (
			.clk(clk),
			.we(bank_we[b]),
			.wr_index(wr_index),
			.wr_lane(wr_lane),
			.wr_data(wr_data),
			.rd_index(rd_index),
			.lanes(bank_lanes[b])
		);
	end

	// Even banks real, odd banks imaginary
	assign wixr_real = bank_lanes[0];
	assign wixr_imag = bank_lanes[1];
	assign wfxr_real = bank_lanes[2];
	assign wfxr_imag = bank_lanes[3];
	assign woxr_real = bank_lanes[4];
	assign woxr_imag = bank_lanes[5];
	assign wcxr_real = bank_lanes[6];
	assign wcxr_imag = bank_lanes[7];

endmodule

//--- bench/tb_stage1_parameter_buffer.sv
`timescale 1ns/1ps

module tb_stage1_parameter_buffer;
	import lstm_weight_pkg::*;
	import axi_map_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int STEPS = DEPTH + 64;
	localparam int LOAD_OPS = 320;
	localparam int OP_CYCLES = 12;
	localparam int WATCHDOG_CYCLES = (STEPS * 3 + LOAD_OPS * OP_CYCLES) * 2;

	logic clk;
	logic reset;
	logic incr_index;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [LANES-1:0][WEIGHT_W-1:0] bank_out [BANKS];

	logic [31:0] rng_state = 32'd604;
	logic [WEIGHT_W-1:0] shadow [BANKS][DEPTH][LANES];
	bit written [BANKS][DEPTH][LANES];
	logic [33:0] read_expect [$];
	logic model_run;
	int model_col;
	int model_row;
	int idx_d1;
	int idx_d2;
	logic [2:0] step_d;
	logic ctrl_write;
	logic rewind_write;
	logic weight_write;

	stage1_parameter_buffer dut_i (
		.clk(clk), .reset(reset), .incr_index(incr_index),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.wixr_real(bank_out[0]), .wixr_imag(bank_out[1]),
		.wfxr_real(bank_out[2]), .wfxr_imag(bank_out[3]),
		.woxr_real(bank_out[4]), .woxr_imag(bank_out[5]),
		.wcxr_real(bank_out[6]), .wcxr_imag(bank_out[7])
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			stop_on_error();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic string bank_name(input int b);
		case (b)
			0: return "wixr_real";
			1: return "wixr_imag";
			2: return "wfxr_real";
			3: return "wfxr_imag";
			4: return "woxr_real";
			5: return "woxr_imag";
			6: return "wcxr_real";
			default: return "wcxr_imag";
		endcase
	endfunction

	function automatic logic [31:0] weight_addr(input int gate, input int part,
			input int index, input int lane);
		return {10'd0, 1'b0, 2'(gate), 1'(part), 12'(index), 4'(lane), 2'b00};
	endfunction

	function automatic logic [31:0] ctrl_addr(input int reg_num);
		return 32'h0020_0000 | (32'(reg_num) << 2);
	endfunction

	function automatic logic [31:0] status_word(input int steps);
		return (32'((steps / COLS) % ROWS) << 8) | 32'(steps % COLS);
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		int delay;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!bvalid);
		// Address stays valid while the response waits
		delay = next_random() % 4;
		repeat (delay) @(negedge clk);
		resp = bresp;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		check_value("bresp", 32'(exp_resp), 32'(resp));
	endtask

	task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		logic [33:0] expect_word;
		logic [31:0] data;
		logic [1:0] resp;
		int delay;
		read_expect.push_back({exp_resp, exp_data});
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		do @(negedge clk); while (!rvalid);
		delay = next_random() % 4;
		repeat (delay) @(negedge clk);
		data = rdata;
		resp = rresp;
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		expect_word = read_expect.pop_front();
		check_value("rresp", 32'(expect_word[33:32]), 32'(resp));
		check_value("rdata", expect_word[31:0], data);
	endtask

	task automatic pulse_incr();
		@(negedge clk);
		incr_index = 1'b1;
		@(negedge clk);
		incr_index = 1'b0;
		@(negedge clk);
	endtask

	assign ctrl_write = awready && awaddr[21] && (awaddr[5:2] == REG_CTRL);
	assign rewind_write = ctrl_write && wdata[CTRL_REWIND];
	assign weight_write = awready && !awaddr[21] && (awaddr[5:2] < LANES)
		&& (awaddr[17:6] < DEPTH);

	// Shadow of accepted lane writes and the col and row model
	always @(posedge clk) begin
		if (weight_write) begin
			shadow[awaddr[20:18]][awaddr[17:6]][awaddr[5:2]] <= wdata[WEIGHT_W-1:0];
			written[awaddr[20:18]][awaddr[17:6]][awaddr[5:2]] <= 1'b1;
		end
		if (reset) begin
			model_run <= 1'b0;
			model_col <= 0;
			model_row <= 0;
			step_d <= '0;
		end else begin
			if (ctrl_write) begin
				model_run <= wdata[CTRL_RUN];
			end
			if (rewind_write) begin
				model_col <= 0;
				model_row <= 0;
			end else if (incr_index && model_run) begin
				if (model_col == COLS - 1) begin
					model_col <= 0;
					model_row <= (model_row == ROWS - 1) ? 0 : model_row + 1;
				end else begin
					model_col <= model_col + 1;
				end
			end
			step_d <= {step_d[1:0], incr_index && model_run && !rewind_write};
		end
		idx_d1 <= model_row * COLS + model_col;
		idx_d2 <= idx_d1;
	end

	// Lanes of the stepped entry hold between the second and third edge after the step
	always @(negedge clk) begin
		if (!reset && step_d[2]) begin
			for (int b = 0; b < BANKS; b++) begin
				for (int l = 0; l < LANES; l++) begin
					if (written[b][idx_d2][l]) begin
						assert (bank_out[b][l] === shadow[b][idx_d2][l]) else begin
							$display("mismatch at %0t: %s[%0d] index %0d expected %h got %h",
								$time, bank_name(b), l, idx_d2, shadow[b][idx_d2][l],
								bank_out[b][l]);
							stop_on_error();
						end
					end
				end
			end
		end
	end

	bvalid_hold_a: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$display("bvalid or bresp changed before bready at %0t", $time);
			stop_on_error();
		end

	rvalid_hold_a: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
		else begin
			$display("rvalid, rresp or rdata changed before rready at %0t", $time);
			stop_on_error();
		end

	no_accept_a: assert property (@(posedge clk) disable iff (reset)
		(bvalid || rvalid) |-> !awready && !wready && !arready)
		else begin
			$display("address accepted while a response was pending at %0t", $time);
			stop_on_error();
		end

	reset_idle_a: assert property (@(posedge clk)
		reset |=> !awready && !wready && !arready && !bvalid && !rvalid)
		else begin
			$display("handshake outputs not low after reset at %0t", $time);
			stop_on_error();
		end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the test sequence finished");
		stop_on_error();
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		incr_index = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		axi_read(ctrl_addr(REG_CTRL), 32'd0, RESP_OKAY);
		axi_read(ctrl_addr(REG_STATUS), 32'd0, RESP_OKAY);
		axi_write(ctrl_addr(REG_CTRL), 32'd1, RESP_OKAY);
		axi_read(ctrl_addr(REG_CTRL), 32'd1, RESP_OKAY);

		// Early writes land near index 0 so the sweep reaches them soon
		for (int i = 0; i < 96; i++) begin
			axi_write(weight_addr(next_random() % GATES, next_random() % 2,
				(i < 32) ? next_random() % 64 : next_random() % DEPTH,
				next_random() % LANES), next_random(), RESP_OKAY);
		end

		axi_write(weight_addr(0, 0, 3, LANES + next_random() % 7), next_random(),
			RESP_SLVERR);
		axi_write(weight_addr(1, 1, DEPTH + next_random() % 1408, 2), next_random(),
			RESP_SLVERR);
		axi_write(ctrl_addr(REG_STATUS), 32'h3, RESP_SLVERR);
		axi_write(ctrl_addr(5), 32'h1, RESP_SLVERR);
		axi_read(weight_addr(2, 0, 7, 1), 32'd0, RESP_SLVERR);

		for (int k = 1; k <= DEPTH; k++) begin
			pulse_incr();
			if (k % 16 == 0) begin
				axi_read(ctrl_addr(REG_STATUS), status_word(k), RESP_OKAY);
			end
		end

		for (int k = 1; k <= 50; k++) begin
			pulse_incr();
		end
		axi_read(ctrl_addr(REG_STATUS), status_word(50), RESP_OKAY);
		axi_write(ctrl_addr(REG_CTRL), 32'd0, RESP_OKAY);
		repeat (5) pulse_incr();
		axi_read(ctrl_addr(REG_STATUS), status_word(50), RESP_OKAY);
		axi_write(ctrl_addr(REG_CTRL), 32'd3, RESP_OKAY);
		axi_read(ctrl_addr(REG_STATUS), 32'd0, RESP_OKAY);
		repeat (3) pulse_incr();
		axi_read(ctrl_addr(REG_STATUS), status_word(3), RESP_OKAY);

		repeat (4) @(negedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- list.f
hdl/lstm_weight_pkg.sv
hdl/axi_map_pkg.sv
hdl/weight_index_counter.sv
hdl/weight_load_slave.sv
hdl/weight_bank.sv
hdl/stage1_parameter_buffer.sv
bench/tb_stage1_parameter_buffer.sv
